// File: common/scanLink_defines.svh
`ifndef SCAN_LINK_DEFINES_SVH
`define SCAN_LINK_DEFINES_SVH

// Serial link framing
`define FRAME_BITS 8 // Bits per byte, MSB first

// Command field inside a received byte
`define CODE_BITS 4 // Low nibble carries the code

// Payload buffering at the station
`define STATION_FIFO_DEPTH 4 // Tagged payload entries

`endif

// File: common/scanLinkPkg.sv
`include "scanLink_defines.svh"

package scanLinkPkg;

	typedef enum logic [`CODE_BITS-1:0] {
		cmdBufferHalf    = `CODE_BITS'd1,
		cmdBuffer80      = `CODE_BITS'd2,
		cmdBuffer90      = `CODE_BITS'd3,
		cmdBufferFull    = `CODE_BITS'd4,
		cmdFlushQuery    = `CODE_BITS'd5, // No action taken
		cmdReadyQuery    = `CODE_BITS'd6, // No action taken
		cmdBinaryFollows = `CODE_BITS'd7,
		cmdAsciiFollows  = `CODE_BITS'd8
	} linkCmd_e;

	typedef enum logic [1:0] {
		orderIdle  = 2'b00,
		orderStart = 2'b01,
		orderFlush = 2'b10
	} scanOrder_e;

	typedef struct packed {
		logic [`FRAME_BITS-`CODE_BITS-1:0] mustBeZero; // Nonzero means not a command
		linkCmd_e                          code;
	} linkCmdView_s;

	// One received byte, seen either as a command or as raw payload
	typedef union packed {
		linkCmdView_s          cmd;
		logic [`FRAME_BITS-1:0] data;
	} linkByte_u;

	typedef struct packed {
		logic                   isAscii; // Set for ASCII payload
		logic [`FRAME_BITS-1:0] payload;
	} fifoEntry_s;

	typedef struct packed {
		logic       readyForTransferOut;
		scanOrder_e scannerOrder; // One-cycle order pulse
	} stationStatus_s;

endpackage

// File: transferCenter/transferCenter.sv
`timescale 1ns/1ps
`include "scanLink_defines.svh"

module transferCenter
	import scanLinkPkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  logic           dataIn,
	input  logic           readyForTransferIn,
	output stationStatus_s status,
	output logic           captureWrite,
	output fifoEntry_s     captureEntry
);

	localparam int counterBits = $clog2(`FRAME_BITS);
	localparam logic [counterBits-1:0] lastBit = counterBits'(`FRAME_BITS - 1);

	logic [`FRAME_BITS-2:0] shiftReg; // Bits already taken this frame
	logic [counterBits-1:0] frameCount;
	logic                   frameDone;
	logic                   armed; // Next byte is payload
	logic                   armedAscii;

	linkByte_u  rxByte;
	logic       isCommand;
	logic       nextReady;
	scanOrder_e nextOrder;
	logic       armRequest;
	logic       armAsAscii;

	assign frameDone = (frameCount == lastBit);

	// Last bit is taken live on the decode edge
	assign rxByte = linkByte_u'({shiftReg, dataIn});

	assign isCommand = (rxByte.cmd.mustBeZero == '0) &&
		(rxByte.cmd.code >= cmdBufferHalf) &&
		(rxByte.cmd.code <= cmdAsciiFollows);

	// Command decode of the completed byte
	always_comb begin
		nextReady  = status.readyForTransferOut; // Hold by default
		nextOrder  = orderIdle;
		armRequest = 1'b0;
		armAsAscii = 1'b0;
		if (isCommand) begin
			case (rxByte.cmd.code)
				cmdBufferHalf: begin
					nextReady = 1'b0;
					nextOrder = orderFlush; // Scanner flushes if waiting
				end
				cmdBuffer80, cmdBufferFull: begin
					nextReady = readyForTransferIn;
				end
				cmdBuffer90: begin
					nextReady = readyForTransferIn;
					nextOrder = orderStart; // Scanner starts scanning
				end
				cmdBinaryFollows: begin
					nextReady  = readyForTransferIn;
					armRequest = 1'b1;
				end
				cmdAsciiFollows: begin
					nextReady  = readyForTransferIn;
					armRequest = 1'b1;
					armAsAscii = 1'b1;
				end
				default: begin
					// Queries change nothing
				end
			endcase
		end
	end

	// Frame counter, status and capture control
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frameCount                 <= '0;
			status.readyForTransferOut <= 1'b0;
			status.scannerOrder        <= orderIdle;
			captureWrite               <= 1'b0;
			armed                      <= 1'b0;
		end else begin
			frameCount          <= frameDone ? '0 : frameCount + 1'b1;
			status.scannerOrder <= orderIdle; // Orders last one cycle
			captureWrite        <= 1'b0;
			if (frameDone) begin
				if (armed) begin
					captureWrite <= 1'b1; // Payload, never decoded
					armed        <= 1'b0;
				end else begin
					status.readyForTransferOut <= nextReady;
					status.scannerOrder        <= nextOrder;
					armed                      <= armRequest;
				end
			end
		end
	end

	// Deserialiser and payload registers
	always_ff @(posedge clk) begin
		shiftReg <= {shiftReg[`FRAME_BITS-3:0], dataIn}; // MSB shifts in first
		if (frameDone && armed) begin
			captureEntry.isAscii <= armedAscii;
			captureEntry.payload <= rxByte.data;
		end
		if (frameDone && !armed && armRequest) begin
			armedAscii <= armAsAscii; // Tag for the next byte
		end
	end

endmodule

// File: source/stationFifo.sv
`timescale 1ns/1ps
`include "scanLink_defines.svh"

module stationFifo
	import scanLinkPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       write,
	input  fifoEntry_s writeEntry,
	input  logic       pop,
	output fifoEntry_s headEntry,
	output logic       dataValid,
	output logic       overflow
);

	localparam int depth     = `STATION_FIFO_DEPTH;
	localparam int ptrBits   = $clog2(depth);
	localparam int countBits = $clog2(depth + 1);
	localparam logic [ptrBits-1:0]   lastSlot  = ptrBits'(depth - 1);
	localparam logic [countBits-1:0] fullCount = countBits'(depth);

	fifoEntry_s mem [depth];

	logic [ptrBits-1:0]   wrPtr;
	logic [ptrBits-1:0]   rdPtr;
	logic [countBits-1:0] occupancy;
	logic                 full;
	logic                 doPop;
	logic                 doPush;

	assign full      = (occupancy == fullCount);
	assign dataValid = (occupancy != '0);
	assign headEntry = mem[rdPtr];

	assign doPop  = pop && dataValid; // Pop on empty is ignored
	assign doPush = write && (!full || doPop); // Full plus pop still accepts

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			occupancy <= '0;
			overflow  <= 1'b0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
			if (write && !doPush) begin
				overflow <= 1'b1; // Sticky until reset
			end
		end
	end

	// Entry storage
	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= writeEntry;
		end
	end

endmodule

// File: source/scanStation.sv
`timescale 1ns/1ps

module scanStation
	import scanLinkPkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  logic           dataIn,
	input  logic           readyForTransferIn,
	input  logic           dataPop,
	output stationStatus_s status,
	output fifoEntry_s     dataEntry,
	output logic           dataValid,
	output logic           overflow
);

	logic       captureWrite;
	fifoEntry_s captureEntry; // Payload byte with its tag

	// Serial link decode
	transferCenter transferCenter (
		.clk                (clk),
		.rst                (rst),
		.dataIn             (dataIn),
		.readyForTransferIn (readyForTransferIn),
		.status             (status),
		.captureWrite       (captureWrite),
		.captureEntry       (captureEntry)
	);

	// Payload buffer toward the outside
	stationFifo stationFifo (
		.clk        (clk),
		.rst        (rst),
		.write      (captureWrite),
		.writeEntry (captureEntry),
		.pop        (dataPop),
		.headEntry  (dataEntry),
		.dataValid  (dataValid),
		.overflow   (overflow)
	);

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0; // Released in the drive slot after the second edge
	end

endmodule

// File: testbench/scanStationChecker.sv
`timescale 1ns/1ps
`include "scanLink_defines.svh"

module scanStationChecker
	import scanLinkPkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  logic           dataIn,
	input  logic           readyForTransferIn,
	input  logic           dataPop,
	input  stationStatus_s status,
	input  fifoEntry_s     dataEntry,
	input  logic           dataValid,
	input  logic           overflow,
	input  int             testId,
	input  logic           runDone,
	output int             errorCount,
	output int             checkCount,
	output logic           reportDone
);

	typedef struct packed {
		logic       ready;
		scanOrder_e order;
		logic       arm;
		logic       armAscii;
		logic       write;
		fifoEntry_s entry;
	} frameResult_s;

	logic [`FRAME_BITS-1:0] rxBits;
	int                     bitCount;
	logic                   expReady;
	scanOrder_e             expOrder;
	logic                   armed;
	logic                   armedAscii;
	logic                   expOverflow;
	logic                   pendWrite; // Capture registered, FIFO takes it next edge
	fifoEntry_s             pendEntry;
	fifoEntry_s             fifoModel[$];
	frameResult_s           result;
	logic                   popNow;
	logic                   pushNow;

	int currentTest;
	int testChecks;
	int testErrors;
	int testsRun;
	int testsFailed;

	// Expected effect of one completed frame
	function automatic frameResult_s predictFrame(input logic [7:0] rxValue,
		input logic armedNow, input logic asciiNow, input logic readyNow, input logic readyIn);
		frameResult_s r;
		r.ready         = readyNow;
		r.order         = orderIdle;
		r.arm           = 1'b0;
		r.armAscii      = asciiNow;
		r.write         = armedNow; // Armed frame is payload only
		r.entry.isAscii = asciiNow;
		r.entry.payload = rxValue;
		if (!armedNow) begin
			if (rxValue == 8'h01) begin
				r.ready = 1'b0;
				r.order = orderFlush;
			end else if (rxValue == 8'h03) begin
				r.ready = readyIn;
				r.order = orderStart;
			end else if (rxValue == 8'h02 || rxValue == 8'h04) begin
				r.ready = readyIn;
			end else if (rxValue == 8'h07 || rxValue == 8'h08) begin
				r.ready    = readyIn;
				r.arm      = 1'b1;
				r.armAscii = (rxValue == 8'h08);
			end
		end
		return r;
	endfunction

	function automatic string testTitle(input int id);
		case (id)
			1:       return "reset state";
			2:       return "readiness";
			3:       return "scanner orders";
			4:       return "payload capture";
			5:       return "overflow";
			default: return "unnamed";
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount = checkCount + 1;
		testChecks = testChecks + 1;
		if (expected !== actual) begin
			errorCount = errorCount + 1;
			testErrors = testErrors + 1;
			$display("Error: %s expected 0x%0h, got 0x%0h at %0t ns",
				name, expected, actual, $time);
		end
	endtask

	task automatic reportTest();
		testsRun = testsRun + 1;
		if (testErrors != 0) begin
			testsFailed = testsFailed + 1;
		end
		$display("Test %0d %s: %0d checks, %0d errors",
			currentTest, testTitle(currentTest), testChecks, testErrors);
		testChecks = 0;
		testErrors = 0;
	endtask

	// Model update on the same edges the DUT uses
	always @(posedge clk) begin
		if (rst) begin
			bitCount    = 0;
			rxBits      = '0;
			expReady    = 1'b0;
			expOrder    = orderIdle;
			armed       = 1'b0;
			armedAscii  = 1'b0;
			expOverflow = 1'b0;
			pendWrite   = 1'b0;
			pendEntry   = '0;
			fifoModel.delete();
		end else begin
			popNow  = dataPop && (fifoModel.size() != 0);
			pushNow = pendWrite && (fifoModel.size() < `STATION_FIFO_DEPTH || popNow);
			if (popNow) begin
				void'(fifoModel.pop_front());
			end
			if (pushNow) begin
				fifoModel.push_back(pendEntry);
			end
			if (pendWrite && !pushNow) begin
				expOverflow = 1'b1; // Entry dropped
			end
			rxBits = {rxBits[`FRAME_BITS-2:0], dataIn};
			if (bitCount == `FRAME_BITS - 1) begin
				result = predictFrame(rxBits, armed, armedAscii, expReady,
					readyForTransferIn);
				expReady   = result.ready;
				expOrder   = result.order;
				armed      = result.arm;
				armedAscii = result.armAscii;
				pendWrite  = result.write;
				pendEntry  = result.entry;
				bitCount   = 0;
			end else begin
				expOrder  = orderIdle;
				pendWrite = 1'b0;
				bitCount  = bitCount + 1;
			end
		end
	end

	// Compare in the middle of the cycle
	always @(negedge clk) begin
		if (rst) begin
			errorCount  = 0;
			checkCount  = 0;
			testChecks  = 0;
			testErrors  = 0;
			testsRun    = 0;
			testsFailed = 0;
			currentTest = 0;
			reportDone  = 1'b0;
		end else if (!reportDone) begin
			if (testId != currentTest) begin
				if (currentTest != 0) begin
					reportTest();
				end
				currentTest = testId;
			end
			checkValue("status.readyForTransferOut", 32'(expReady),
				32'(status.readyForTransferOut));
			checkValue("status.scannerOrder", 32'(expOrder), 32'(status.scannerOrder));
			checkValue("dataValid", 32'(fifoModel.size() != 0), 32'(dataValid));
			checkValue("overflow", 32'(expOverflow), 32'(overflow));
			if (fifoModel.size() != 0) begin
				checkValue("dataEntry", 32'(fifoModel[0]), 32'(dataEntry));
			end
			if (runDone) begin
				reportTest();
				$display("Totals: %0d tests run, %0d failed, %0d checks, %0d errors",
					testsRun, testsFailed, checkCount, errorCount);
				reportDone = 1'b1;
			end
		end
	end

endmodule

// File: testbench/scanStation_asserts.sv
`timescale 1ns/1ps
`include "scanLink_defines.svh"

module scanStationAsserts
	import scanLinkPkg::*;
(
	input logic                                       clk,
	input logic                                       rst,
	input scanOrder_e                                 order,
	input logic                                       captureWrite,
	input logic                                       frameDone,
	input logic                                       armed,
	input logic [$clog2(`STATION_FIFO_DEPTH + 1)-1:0] occupancy
);

	localparam int countBits = $clog2(`STATION_FIFO_DEPTH + 1);
	localparam logic [countBits-1:0] depthLimit = countBits'(`STATION_FIFO_DEPTH);

	orderPulse: assert property (@(posedge clk) disable iff (rst)
		(order != orderIdle) |=> (order == orderIdle))
		else $error("Scanner order held longer than one cycle");

	// Write must come from a frame that ended while armed
	captureAfterArm: assert property (@(posedge clk) disable iff (rst)
		captureWrite |-> $past(frameDone && armed))
		else $error("Capture write without an armed frame");

	occupancyBound: assert property (@(posedge clk) disable iff (rst)
		occupancy <= depthLimit)
		else $error("FIFO occupancy above its depth");

endmodule

bind transferCenter scanStationAsserts linkChecks (
	.clk          (clk),
	.rst          (rst),
	.order        (status.scannerOrder),
	.captureWrite (captureWrite),
	.frameDone    (frameDone),
	.armed        (armed),
	.occupancy    ('0) // No buffer in this block
);

bind stationFifo scanStationAsserts fifoChecks (
	.clk          (clk),
	.rst          (rst),
	.order        (scanLinkPkg::orderIdle),
	.captureWrite (1'b0),
	.frameDone    (1'b0),
	.armed        (1'b0),
	.occupancy    (occupancy)
);

// File: testbench/scanStationTb.sv
`timescale 1ns/1ps
`include "scanLink_defines.svh"

module scanStationTb
	import scanLinkPkg::*;
();

	localparam int totalFrames   = 2 + 17 + 12 + 25 + 13; // Frames of tests 1 to 5
	localparam int timeoutCycles = `FRAME_BITS * totalFrames + 200;

	logic           clk;
	logic           rst;
	logic           dataIn;
	logic           readyForTransferIn;
	logic           dataPop;
	stationStatus_s status;
	fifoEntry_s     dataEntry;
	logic           dataValid;
	logic           overflow;

	int          testId;
	logic        runDone;
	int          errorCount;
	int          checkCount;
	logic        reportDone;
	int          cycleCount = 0;
	logic [15:0] lfsrState;

	tbClock clockGen (
		.clk (clk),
		.rst (rst)
	);

	scanStation DUT (
		.clk                (clk),
		.rst                (rst),
		.dataIn             (dataIn),
		.readyForTransferIn (readyForTransferIn),
		.dataPop            (dataPop),
		.status             (status),
		.dataEntry          (dataEntry),
		.dataValid          (dataValid),
		.overflow           (overflow)
	);

	scanStationChecker portChecker (
		.clk                (clk),
		.rst                (rst),
		.dataIn             (dataIn),
		.readyForTransferIn (readyForTransferIn),
		.dataPop            (dataPop),
		.status             (status),
		.dataEntry          (dataEntry),
		.dataValid          (dataValid),
		.overflow           (overflow),
		.testId             (testId),
		.runDone            (runDone),
		.errorCount         (errorCount),
		.checkCount         (checkCount),
		.reportDone         (reportDone)
	);

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	function automatic logic randomBit();
		lfsrState = lfsrStep(lfsrState);
		return lfsrState[0];
	endfunction

	function automatic logic [7:0] randomByte();
		logic [7:0] value;
		int         bitIdx;
		value = '0;
		for (bitIdx = 0; bitIdx < 8; bitIdx++) begin
			value = {value[6:0], randomBit()};
		end
		return value;
	endfunction

	function automatic logic [7:0] randomNonCommand();
		logic [7:0] value;
		value = randomByte();
		if (value[7:4] == 4'h0 && value[3:0] >= 4'd1 && value[3:0] <= 4'd8) begin
			value[7] = 1'b1; // Out of the command range
		end
		return value;
	endfunction

	// One frame MSB first, pop strobes in its first slots
	task automatic sendByte(input logic [`FRAME_BITS-1:0] value, input logic ready,
		input int pops);
		logic [`FRAME_BITS-1:0] shiftOut;
		int                     slot;
		shiftOut = value;
		for (slot = 0; slot < `FRAME_BITS; slot++) begin
			dataIn             = shiftOut[`FRAME_BITS-1];
			readyForTransferIn = ready;
			dataPop            = (slot < pops);
			shiftOut           = shiftOut << 1;
			@(posedge clk);
			#1;
		end
		dataPop = 1'b0;
	endtask

	initial begin
		logic [47:0] codeList;
		logic [7:0]  code;
		logic [7:0]  payload;
		int          round;
		int          k;
		dataIn             = 1'b0;
		readyForTransferIn = 1'b0;
		dataPop            = 1'b0;
		testId             = 0;
		runDone            = 1'b0;
		lfsrState          = 16'd53843;
		@(negedge rst);

		testId = 1;
		sendByte(8'h00, 1'b1, 1); // Not a command, pop on empty
		sendByte(8'h00, randomBit(), 0);

		testId = 2;
		for (round = 0; round < 2; round++) begin
			codeList = {8'h01, 8'h02, 8'h03, 8'h04, 8'h07, 8'h08};
			for (k = 0; k < 6; k++) begin
				code     = codeList[47:40];
				codeList = codeList << 8;
				sendByte(code, randomBit(), 0);
				if (code == 8'h07 || code == 8'h08) begin
					sendByte(randomByte(), randomBit(), 0); // Payload behind arm code
				end
			end
		end
		sendByte(8'h00, randomBit(), 4); // Drains four payloads

		testId = 3;
		sendByte(8'h01, randomBit(), 0);
		sendByte(8'h03, randomBit(), 0);
		sendByte(8'h05, randomBit(), 0);
		sendByte(8'h06, randomBit(), 0);
		for (k = 0; k < 6; k++) begin
			sendByte(randomNonCommand(), randomBit(), 0);
		end
		sendByte(8'h03, randomBit(), 0);
		sendByte(8'h01, randomBit(), 0);

		testId = 4;
		for (k = 0; k < 12; k++) begin
			code = randomBit() ? 8'h08 : 8'h07;
			if (k < 8) begin
				payload = 8'(k + 1); // Looks like a command code
			end else begin
				payload = randomByte();
			end
			sendByte(code, randomBit(), 2);
			sendByte(payload, randomBit(), 0);
		end
		sendByte(8'h00, randomBit(), 2);

		testId = 5;
		for (k = 0; k < 5; k++) begin
			code = randomBit() ? 8'h08 : 8'h07;
			sendByte(code, randomBit(), 0);
			sendByte(randomByte(), randomBit(), 0);
		end
		sendByte(8'h00, randomBit(), 0); // Fifth write meets a full FIFO
		sendByte(8'h00, randomBit(), 4);
		sendByte(8'h00, randomBit(), 2);

		runDone = 1'b1;
		wait (reportDone);
		if (errorCount == 0 && checkCount > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

// File: sources.f
+incdir+common
common/scanLinkPkg.sv
transferCenter/transferCenter.sv
source/stationFifo.sv
source/scanStation.sv
testbench/tbClock.sv
testbench/scanStationChecker.sv
testbench/scanStation_asserts.sv
testbench/scanStationTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the scan station testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module scanStationTb -f sources.f -o scanStationSim \
	|| { echo "Build failed"; exit 1; }

simOutput="$(./obj_dir/scanStationSim 2>&1)"
echo "$simOutput"

echo "$simOutput" | grep -q "ALL TESTS PASSED" \
	&& echo "Run passed" \
	|| { echo "Run failed"; exit 1; }
